//--- include/usb_rx_config.svh
`ifndef USB_RX_CONFIG_SVH
`define USB_RX_CONFIG_SVH

// Merger FIFO beats, one of them held back for the status beat
`define USB_RX_FIFO_DEPTH 16

// Credits held by the merger after reset
`define USB_RX_CREDITS 4

// CRC16 register after a data payload and its CRC, x^15 as the MSB
`define USB_CRC16_RESIDUE 16'h800d

// CRC5 remainder xor the bit-reversed token CRC field when they agree
`define USB_CRC5_RESIDUE 5'h1f

`endif

//--- logic/usb_rx_pkg.sv
`default_nettype none

package usb_rx_pkg;

  // Low two PID bits
  typedef enum logic [1:0] {
    PID_SPECIAL   = 2'b00,
    PID_TOKEN     = 2'b01,
    PID_HANDSHAKE = 2'b10,
    PID_DATA      = 2'b11
  } pid_class_e;

  // First four follow PID bits 3:2 of the token PIDs
  typedef enum logic [2:0] {
    TOK_OUT   = 3'd0,
    TOK_SOF   = 3'd1,
    TOK_IN    = 3'd2,
    TOK_SETUP = 3'd3,
    TOK_PING  = 3'd4
  } token_kind_e;

  typedef enum logic [1:0] {
    FR_IDLE,
    FR_PID,
    FR_BODY
  } framer_state_e;

  typedef enum logic [1:0] {
    ST_OK        = 2'd0,
    ST_CRC_ERROR = 2'd1,
    ST_RX_ERROR  = 2'd2,
    ST_OVERFLOW  = 2'd3
  } rx_status_e;

  // Upper nibble carries the complement of the lower one
  function automatic logic pid_is_valid(input logic [7:0] pid);
    return pid[3:0] == ~pid[7:4];
  endfunction

  // Token PIDs plus PING, which shares the token layout
  function automatic logic pid_is_token(input logic [3:0] pid);
    return pid[1:0] == PID_TOKEN || pid == 4'b0100;
  endfunction

  // x^5 + x^2 + 1 over the 11 token bits, bit 0 first
  function automatic logic [4:0] crc5(input logic [10:0] d);
    logic [4:0] r;
    logic fb;
    int i;
    r = 5'h1f;
    for (i = 0; i < 11; i++) begin
      fb = d[i] ^ r[4];
      r = {r[3:0], 1'b0};
      if (fb) begin
        r = r ^ 5'h05;
      end
    end
    return r;
  endfunction

  // x^16 + x^15 + x^2 + 1, one byte LSB first onto the running value
  function automatic logic [15:0] crc16(input logic [7:0] d, input logic [15:0] c);
    logic [15:0] r;
    logic fb;
    int i;
    r = c;
    for (i = 0; i < 8; i++) begin
      fb = d[i] ^ r[15];
      r = {r[14:0], 1'b0};
      if (fb) begin
        r = r ^ 16'h8005;
      end
    end
    return r;
  endfunction

endpackage

`default_nettype wire

//--- logic/usb_byte_if.sv
`timescale 1ns/100ps
`default_nettype none

interface usb_byte_if;
  // No handshake, a beat is taken whenever valid is high
  logic valid;
  // PID byte of a packet
  logic first;
  // Closing beat without data
  logic last;
  // Packet cut short by RxError or a dir drop
  logic abort;
  logic [7:0] data;

  modport source (output valid, first, last, abort, data);

  modport sink (input valid, first, last, abort, data);

endinterface

`default_nettype wire

//--- logic/ulpi_rx_framer.sv
`timescale 1ns/100ps
`default_nettype none

module ulpi_rx_framer (
  input wire logic       clock,
  input wire logic       reset,
  input wire logic       ulpi_dir_i,
  input wire logic       ulpi_nxt_i,
  input wire logic [7:0] ulpi_data_i,
  usb_byte_if.source     bytes_o
);
  import usb_rx_pkg::*;

  framer_state_e state_q;
  logic dir_q;
  logic rx_cmd;
  logic rx_byte;
  logic rx_error;
  logic rx_end;

  // Bus owned by the PHY past turnaround, nxt tells data from RX_CMD
  assign rx_cmd = ulpi_dir_i && dir_q && !ulpi_nxt_i;
  assign rx_byte = ulpi_dir_i && dir_q && ulpi_nxt_i;

  // RxEvent sits in bits 5:4, 2'b11 means RxError
  assign rx_error = rx_cmd && ulpi_data_i[5:4] == 2'b11;

  // RxActive gone, RxError, or the PHY released the bus
  assign rx_end = (rx_cmd && !ulpi_data_i[4]) || rx_error || !ulpi_dir_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= FR_IDLE;
      dir_q <= 1'b0;
      bytes_o.valid <= 1'b0;
      bytes_o.first <= 1'b0;
      bytes_o.last <= 1'b0;
      bytes_o.abort <= 1'b0;
    end else begin
      dir_q <= ulpi_dir_i;
      bytes_o.valid <= 1'b0;
      bytes_o.first <= 1'b0;
      bytes_o.last <= 1'b0;
      bytes_o.abort <= 1'b0;
      case (state_q)
        FR_IDLE: begin
          if (rx_cmd && ulpi_data_i[4] && !rx_error) begin
            state_q <= FR_PID;
          end
        end
        FR_PID: begin
          // Nothing received yet, so an end here leaves no packet
          if (rx_end) begin
            state_q <= FR_IDLE;
          end else if (rx_byte) begin
            bytes_o.valid <= 1'b1;
            bytes_o.first <= 1'b1;
            state_q <= FR_BODY;
          end
        end
        FR_BODY: begin
          if (rx_end) begin
            bytes_o.valid <= 1'b1;
            bytes_o.last <= 1'b1;
            bytes_o.abort <= rx_error || !ulpi_dir_i;
            state_q <= FR_IDLE;
          end else if (rx_byte) begin
            bytes_o.valid <= 1'b1;
          end
        end
        default: state_q <= FR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (rx_byte) begin
      bytes_o.data <= ulpi_data_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/usb_token_parser.sv
`timescale 1ns/100ps
`default_nettype none

`include "usb_rx_config.svh"

module usb_token_parser (
  input wire logic                 clock,
  input wire logic                 reset,
  usb_byte_if.sink                 bytes_i,
  output logic                     tok_done_o,
  output logic                     tok_ok_o,
  output usb_rx_pkg::token_kind_e  tok_kind_o,
  output logic [6:0]               tok_addr_o,
  output logic [3:0]               tok_endp_o
);
  import usb_rx_pkg::*;

  logic pid_ok_q;
  logic tok_pid_q;
  // Bytes after the PID, stops counting at 3
  logic [1:0] len_q;
  logic [10:0] field_q;
  logic [4:0] crc_rev_q;
  logic end_beat;
  logic crc_match;

  assign end_beat = bytes_i.valid && bytes_i.last;
  assign crc_match = (crc5(field_q) ^ crc_rev_q) == `USB_CRC5_RESIDUE;

  // Address in the low seven field bits, endpoint above
  assign tok_addr_o = field_q[6:0];
  assign tok_endp_o = field_q[10:7];

  always_ff @(posedge clock) begin
    if (reset) begin
      tok_done_o <= 1'b0;
      tok_ok_o <= 1'b0;
    end else begin
      tok_done_o <= end_beat;
      tok_ok_o <= end_beat && !bytes_i.abort && tok_pid_q && pid_ok_q &&
                  len_q == 2'd2 && crc_match;
    end
  end

  always_ff @(posedge clock) begin
    if (bytes_i.valid && bytes_i.first) begin
      pid_ok_q <= pid_is_valid(bytes_i.data);
      tok_pid_q <= pid_is_token(bytes_i.data[3:0]);
      if (pid_class_e'(bytes_i.data[1:0]) == PID_TOKEN) begin
        tok_kind_o <= token_kind_e'({1'b0, bytes_i.data[3:2]});
      end else begin
        tok_kind_o <= TOK_PING;
      end
      len_q <= 2'd0;
    end else if (bytes_i.valid && !bytes_i.last) begin
      case (len_q)
        2'd0: field_q[7:0] <= bytes_i.data;
        2'd1: begin
          field_q[10:8] <= bytes_i.data[2:0];
          // CRC5 arrives x^4 first in bit 3
          crc_rev_q <= {bytes_i.data[3], bytes_i.data[4], bytes_i.data[5],
                        bytes_i.data[6], bytes_i.data[7]};
        end
        default: ;
      endcase
      if (len_q != 2'd3) begin
        len_q <= len_q + 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/usb_crc16_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "usb_rx_config.svh"

module usb_crc16_checker (
  input wire logic                clock,
  input wire logic                reset,
  usb_byte_if.sink                bytes_i,
  output logic                    chk_done_o,
  output usb_rx_pkg::rx_status_e  chk_status_o,
  output logic                    is_token_o
);
  import usb_rx_pkg::*;

  pid_class_e class_q;
  logic pid_ok_q;
  // Any byte after the PID
  logic body_q;
  logic [15:0] crc_q;
  rx_status_e status_w;

  always_comb begin
    if (bytes_i.abort || !pid_ok_q) begin
      status_w = ST_RX_ERROR;
    end else begin
      case (class_q)
        PID_HANDSHAKE: status_w = body_q ? ST_RX_ERROR : ST_OK;
        PID_DATA: status_w = (crc_q == `USB_CRC16_RESIDUE) ? ST_OK : ST_CRC_ERROR;
        PID_TOKEN: status_w = ST_OK;
        // PING is the only special PID taken here
        default: status_w = is_token_o ? ST_OK : ST_RX_ERROR;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      chk_done_o <= 1'b0;
    end else begin
      chk_done_o <= bytes_i.valid && bytes_i.last;
    end
  end

  always_ff @(posedge clock) begin
    if (bytes_i.valid && bytes_i.first) begin
      class_q <= pid_class_e'(bytes_i.data[1:0]);
      pid_ok_q <= pid_is_valid(bytes_i.data);
      is_token_o <= pid_is_token(bytes_i.data[3:0]);
      body_q <= 1'b0;
      crc_q <= 16'hffff;
    end else if (bytes_i.valid && !bytes_i.last) begin
      body_q <= 1'b1;
      crc_q <= crc16(bytes_i.data, crc_q);
    end
    if (bytes_i.valid && bytes_i.last) begin
      chk_status_o <= status_w;
    end
  end

endmodule

`default_nettype wire

//--- logic/usb_rx_merger.sv
`timescale 1ns/100ps
`default_nettype none

`include "usb_rx_config.svh"

module usb_rx_merger (
  input wire logic                      clock,
  input wire logic                      reset,
  usb_byte_if.sink                      bytes_i,
  input wire logic                      tok_done_i,
  input wire logic                      tok_ok_i,
  input wire usb_rx_pkg::token_kind_e   tok_kind_i,
  input wire logic [6:0]                tok_addr_i,
  input wire logic [3:0]                tok_endp_i,
  input wire logic                      chk_done_i,
  input wire usb_rx_pkg::rx_status_e    chk_status_i,
  input wire logic                      is_token_i,
  input wire logic                      credit_return_i,
  output logic                          rx_valid_o,
  output logic [7:0]                    rx_data_o,
  output logic [3:0]                    rx_pid_o,
  output logic                          rx_last_o,
  output usb_rx_pkg::rx_status_e        rx_status_o,
  output logic                          tok_valid_o,
  output usb_rx_pkg::token_kind_e       tok_kind_o,
  output logic [6:0]                    tok_addr_o,
  output logic [3:0]                    tok_endp_o,
  output logic                          sof_o
);
  import usb_rx_pkg::*;

  localparam int AW = $clog2(`USB_RX_FIFO_DEPTH);
  localparam int CW = $clog2(`USB_RX_CREDITS + 1) + 1;
  localparam logic [AW:0] DEPTH = (AW + 1)'(`USB_RX_FIFO_DEPTH);

  // Each entry is {last, data}, a status beat keeps its status in data[1:0]
  logic [8:0] fifo_mem [`USB_RX_FIFO_DEPTH];
  logic [AW:0] wr_ptr_q;
  logic [AW:0] rd_ptr_q;
  logic [AW:0] fill;
  logic [CW-1:0] credit_q;
  logic active_q;
  logic overflow_q;
  logic out_first_q;
  logic full;
  logic room;
  logic take;
  logic wr_byte;
  logic drop;
  logic status_wr;
  logic pop;
  logic [8:0] head;
  rx_status_e status_w;

  assign fill = wr_ptr_q - rd_ptr_q;
  assign full = fill == DEPTH;
  assign room = fill < DEPTH - 1'b1;

  // A packet opens on its PID unless it is a token or not even a status beat fits
  assign take = bytes_i.valid && !bytes_i.last &&
                (bytes_i.first ? (!pid_is_token(bytes_i.data[3:0]) && !full) : active_q);
  assign wr_byte = take && room;
  assign drop = take && !room;
  assign status_wr = chk_done_i && active_q && !is_token_i;
  assign status_w = overflow_q ? ST_OVERFLOW : chk_status_i;

  assign head = fifo_mem[rd_ptr_q[AW-1:0]];
  // The beat already on the output spends a credit too
  assign pop = fill != '0 && credit_q > CW'(rx_valid_o);

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      credit_q <= CW'(`USB_RX_CREDITS);
      active_q <= 1'b0;
      overflow_q <= 1'b0;
      out_first_q <= 1'b1;
      rx_valid_o <= 1'b0;
      rx_last_o <= 1'b0;
      tok_valid_o <= 1'b0;
      sof_o <= 1'b0;
    end else begin
      if (status_wr || wr_byte) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        out_first_q <= head[8];
      end
      credit_q <= credit_q - CW'(rx_valid_o) + CW'(credit_return_i);
      if (bytes_i.valid && bytes_i.first) begin
        active_q <= take;
        overflow_q <= drop;
      end else begin
        if (drop) begin
          overflow_q <= 1'b1;
        end
        if (chk_done_i) begin
          active_q <= 1'b0;
        end
      end
      rx_valid_o <= pop;
      rx_last_o <= pop && head[8];
      tok_valid_o <= tok_done_i && tok_ok_i;
      sof_o <= tok_done_i && tok_ok_i && tok_kind_i == TOK_SOF;
    end
  end

  always_ff @(posedge clock) begin
    if (status_wr) begin
      fifo_mem[wr_ptr_q[AW-1:0]] <= {1'b1, 6'd0, status_w};
    end else if (wr_byte) begin
      fifo_mem[wr_ptr_q[AW-1:0]] <= {1'b0, bytes_i.data};
    end
    if (pop) begin
      rx_data_o <= head[7:0];
      rx_status_o <= head[8] ? rx_status_e'(head[1:0]) : ST_OK;
      // PID of the packet now leaving, taken from its first beat
      if (out_first_q) begin
        rx_pid_o <= head[3:0];
      end
    end
    if (tok_done_i) begin
      tok_kind_o <= tok_kind_i;
      tok_addr_o <= tok_addr_i;
      tok_endp_o <= tok_endp_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/usb_ulpi_rx.sv
`timescale 1ns/100ps
`default_nettype none

module usb_ulpi_rx (
  input wire logic                 clock,
  input wire logic                 reset,
  input wire logic                 ulpi_dir_i,
  input wire logic                 ulpi_nxt_i,
  input wire logic [7:0]           ulpi_data_i,
  input wire logic                 credit_return_i,
  output logic                     rx_valid_o,
  output logic [7:0]               rx_data_o,
  output logic [3:0]               rx_pid_o,
  output logic                     rx_last_o,
  output usb_rx_pkg::rx_status_e   rx_status_o,
  output logic                     tok_valid_o,
  output usb_rx_pkg::token_kind_e  tok_kind_o,
  output logic [6:0]               tok_addr_o,
  output logic [3:0]               tok_endp_o,
  output logic                     sof_o
);
  import usb_rx_pkg::*;

  usb_byte_if bytes ();

  logic tok_done;
  logic tok_ok;
  token_kind_e tok_kind;
  logic [6:0] tok_addr;
  logic [3:0] tok_endp;
  logic chk_done;
  rx_status_e chk_status;
  logic is_token;

  ulpi_rx_framer u_framer (
    .clock       (clock),
    .reset       (reset),
    .ulpi_dir_i  (ulpi_dir_i),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .ulpi_data_i (ulpi_data_i),
    .bytes_o     (bytes.source)
  );

  // Parser and checker see the same beats
  usb_token_parser u_parser (
    .clock      (clock),
    .reset      (reset),
    .bytes_i    (bytes.sink),
    .tok_done_o (tok_done),
    .tok_ok_o   (tok_ok),
    .tok_kind_o (tok_kind),
    .tok_addr_o (tok_addr),
    .tok_endp_o (tok_endp)
  );

  usb_crc16_checker u_checker (
    .clock        (clock),
    .reset        (reset),
    .bytes_i      (bytes.sink),
    .chk_done_o   (chk_done),
    .chk_status_o (chk_status),
    .is_token_o   (is_token)
  );

  usb_rx_merger u_merger (
    .clock           (clock),
    .reset           (reset),
    .bytes_i         (bytes.sink),
    .tok_done_i      (tok_done),
    .tok_ok_i        (tok_ok),
    .tok_kind_i      (tok_kind),
    .tok_addr_i      (tok_addr),
    .tok_endp_i      (tok_endp),
    .chk_done_i      (chk_done),
    .chk_status_i    (chk_status),
    .is_token_i      (is_token),
    .credit_return_i (credit_return_i),
    .rx_valid_o      (rx_valid_o),
    .rx_data_o       (rx_data_o),
    .rx_pid_o        (rx_pid_o),
    .rx_last_o       (rx_last_o),
    .rx_status_o     (rx_status_o),
    .tok_valid_o     (tok_valid_o),
    .tok_kind_o      (tok_kind_o),
    .tok_addr_o      (tok_addr_o),
    .tok_endp_o      (tok_endp_o),
    .sof_o           (sof_o)
  );

endmodule

`default_nettype wire

//--- verification/usb_rx_properties.sv
`timescale 1ns/100ps
`default_nettype none

module usb_rx_properties (
  input wire logic       clock,
  input wire logic       reset,
  input wire logic [3:0] credit_i,
  input wire logic       rx_valid_i,
  input wire logic       rx_last_i,
  input wire logic [1:0] rx_status_i,
  input wire logic       tok_valid_i
);

  // A beat may only leave while a credit is held
  assert property (@(posedge clock) disable iff (reset) rx_valid_i |-> credit_i != 4'd0)
    else $error("rx_valid_o high with no credits left");

  assert property (@(posedge clock) disable iff (reset) rx_last_i |-> !$isunknown(rx_status_i))
    else $error("rx_status_o unknown on the last beat");

  // Outputs quiet right after reset
  assert property (@(posedge clock) reset |=> !tok_valid_i && !rx_valid_i)
    else $error("tok_valid_o or rx_valid_o high after reset");

endmodule

bind usb_rx_merger usb_rx_properties u_properties (
  .clock       (clock),
  .reset       (reset),
  .credit_i    (credit_q),
  .rx_valid_i  (rx_valid_o),
  .rx_last_i   (rx_last_o),
  .rx_status_i (rx_status_o),
  .tok_valid_i (tok_valid_o)
);

`default_nettype wire

//--- verification/usb_rx_monitor.sv
`timescale 1ns/100ps
`default_nettype none

module usb_rx_monitor (
  input wire logic       clock,
  input wire logic       reset,
  input wire logic       rx_valid_i,
  input wire logic [7:0] rx_data_i,
  input wire logic [3:0] rx_pid_i,
  input wire logic       rx_last_i,
  input wire logic [1:0] rx_status_i,
  input wire logic       tok_valid_i,
  input wire logic [2:0] tok_kind_i,
  input wire logic [6:0] tok_addr_i,
  input wire logic [3:0] tok_endp_i,
  input wire logic       sof_i,
  input wire logic       start_i,
  input wire logic [7:0] test_i,
  input wire logic [1:0] type_i,
  input wire logic [1:0] status_i,
  input wire logic [2:0] kind_i,
  input wire logic [6:0] addr_i,
  input wire logic [3:0] endp_i,
  input wire logic [7:0] kept_i,
  input wire logic [7:0] bytes_i [32],
  input var int          end_cycle_i,
  input var int          cycle_i,
  output logic           done_o,
  output int             tests_o,
  output int             fails_o
);

  logic bad_q;

  initial begin
    done_o = 1'b0;
    tests_o = 0;
    fails_o = 0;
  end

  task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] got);
    if (got !== exp) begin
      $display("** Error test %0d: %s expected %h got %h", test_i, name, exp, got);
      bad_q = 1'b1;
    end
  endtask

  task automatic check_test();
    int idx;
    int wait_cnt;
    logic seen;
    idx = 0;
    wait_cnt = 0;
    seen = 1'b0;
    bad_q = 1'b0;
    // Type 0 stream packet, 1 token pulse, 2 nothing at all
    while (!seen && wait_cnt < (type_i == 2'd2 ? 30 : 800)) begin
      @(negedge clock);
      wait_cnt++;
      if (type_i != 2'd1) begin
        compare("tok_valid_o", 8'h00, {7'd0, tok_valid_i});
      end
      if (type_i != 2'd0) begin
        compare("rx_valid_o", 8'h00, {7'd0, rx_valid_i});
      end
      if (type_i == 2'd0 && rx_valid_i) begin
        compare("rx_pid_o", {4'h0, bytes_i[0][3:0]}, {4'h0, rx_pid_i});
        if (rx_last_i) begin
          seen = 1'b1;
          compare("rx_status_o", {6'd0, status_i}, {6'd0, rx_status_i});
          if (idx != int'(kept_i)) begin
            $display("test %0d: %0d bytes delivered but %0d expected", test_i, idx, kept_i);
            bad_q = 1'b1;
          end
        end else if (idx < int'(kept_i)) begin
          compare("rx_data_o", bytes_i[idx], rx_data_i);
          idx++;
        end else begin
          $display("test %0d: more bytes delivered than expected", test_i);
          bad_q = 1'b1;
        end
      end
      if (type_i == 2'd1 && tok_valid_i) begin
        seen = 1'b1;
        compare("tok_kind_o", {5'd0, kind_i}, {5'd0, tok_kind_i});
        compare("tok_addr_o", {1'b0, addr_i}, {1'b0, tok_addr_i});
        compare("tok_endp_o", {4'h0, endp_i}, {4'h0, tok_endp_i});
        compare("sof_o", {7'd0, kind_i == 3'd1}, {7'd0, sof_i});
        if (cycle_i - end_cycle_i != 3) begin
          $display("test %0d: token came %0d clocks after the end condition, not 3",
                   test_i, cycle_i - end_cycle_i);
          bad_q = 1'b1;
        end
      end
    end
    if (!seen && type_i != 2'd2) begin
      $display("test %0d: timeout waiting for the expected output", test_i);
      bad_q = 1'b1;
    end
    tests_o = tests_o + 1;
    if (bad_q) begin
      fails_o = fails_o + 1;
      $display("test %0d: fail", test_i);
    end else begin
      $display("test %0d: ok", test_i);
    end
    done_o = 1'b1;
    @(negedge clock);
    done_o = 1'b0;
  endtask

  always @(negedge clock) begin
    if (!reset && start_i) begin
      check_test();
    end
  end

endmodule

`default_nettype wire

//--- verification/usb_ulpi_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module usb_ulpi_rx_tb;

  logic clock;
  logic reset = 1'b1;
  logic ulpi_dir = 1'b0;
  logic ulpi_nxt = 1'b0;
  logic [7:0] ulpi_data = 8'h00;
  logic credit_return = 1'b0;
  logic rx_valid;
  logic [7:0] rx_data;
  logic [3:0] rx_pid;
  logic rx_last;
  logic [1:0] rx_status;
  logic tok_valid;
  logic [2:0] tok_kind;
  logic [6:0] tok_addr;
  logic [3:0] tok_endp;
  logic sof;

  // Test records from the data file
  logic [7:0] mem [1024];
  logic [7:0] exp_bytes [32];
  logic [7:0] test_no = 8'h00;
  logic [7:0] mode;
  logic [7:0] count;
  logic [1:0] exp_type = 2'd0;
  logic [1:0] exp_status = 2'd0;
  logic [2:0] exp_kind = 3'd0;
  logic [6:0] exp_addr = 7'd0;
  logic [3:0] exp_endp = 4'd0;
  logic [7:0] exp_kept = 8'd0;
  logic start = 1'b0;
  logic hold = 1'b0;
  logic timed_out = 1'b0;
  logic done;
  int fails;
  int tests;
  int cycle = 0;
  int end_cycle = 0;
  int owed = 0;
  int p;
  int q;
  int i;
  logic [31:0] stim_lfsr = 32'ha2e4c29a;
  logic [31:0] credit_lfsr = 32'ha2e4c29a;

  usb_ulpi_rx i_dut (
    .clock           (clock),
    .reset           (reset),
    .ulpi_dir_i      (ulpi_dir),
    .ulpi_nxt_i      (ulpi_nxt),
    .ulpi_data_i     (ulpi_data),
    .credit_return_i (credit_return),
    .rx_valid_o      (rx_valid),
    .rx_data_o       (rx_data),
    .rx_pid_o        (rx_pid),
    .rx_last_o       (rx_last),
    .rx_status_o     (rx_status),
    .tok_valid_o     (tok_valid),
    .tok_kind_o      (tok_kind),
    .tok_addr_o      (tok_addr),
    .tok_endp_o      (tok_endp),
    .sof_o           (sof)
  );

  usb_rx_monitor i_monitor (
    .clock       (clock),
    .reset       (reset),
    .rx_valid_i  (rx_valid),
    .rx_data_i   (rx_data),
    .rx_pid_i    (rx_pid),
    .rx_last_i   (rx_last),
    .rx_status_i (rx_status),
    .tok_valid_i (tok_valid),
    .tok_kind_i  (tok_kind),
    .tok_addr_i  (tok_addr),
    .tok_endp_i  (tok_endp),
    .sof_i       (sof),
    .start_i     (start),
    .test_i      (test_no),
    .type_i      (exp_type),
    .status_i    (exp_status),
    .kind_i      (exp_kind),
    .addr_i      (exp_addr),
    .endp_i      (exp_endp),
    .kept_i      (exp_kept),
    .bytes_i     (exp_bytes),
    .end_cycle_i (end_cycle),
    .cycle_i     (cycle),
    .done_o      (done),
    .tests_o     (tests),
    .fails_o     (fails)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic gap_bit();
    stim_lfsr = lfsr_step(stim_lfsr);
    return stim_lfsr[0];
  endfunction

  // One credit back per beat, spaced out by the LFSR
  always @(posedge clock) begin : credit_gen
    logic [31:0] next;
    logic give;
    next = lfsr_step(credit_lfsr);
    give = !hold && (owed != 0 || rx_valid) && next[0];
    if (reset) begin
      credit_lfsr <= 32'ha2e4c29a;
      owed <= 0;
      credit_return <= 1'b0;
    end else begin
      credit_lfsr <= next;
      credit_return <= give;
      owed <= owed + int'(rx_valid) - int'(give);
    end
  end

  task automatic drive_cycle(input logic dir, input logic nxt, input logic [7:0] data);
    @(posedge clock);
    start <= 1'b0;
    ulpi_dir <= dir;
    ulpi_nxt <= nxt;
    ulpi_data <= data;
  endtask

  task automatic send_packet();
    int n;
    int wait_cnt;
    wait_cnt = 0;
    // All credits back in the merger before the next packet
    while (!(owed == 0 && !rx_valid && !credit_return) && wait_cnt < 300) begin
      @(posedge clock);
      wait_cnt++;
    end
    if (wait_cnt >= 300) begin
      $display("timeout waiting for credits to return before test %0d", test_no);
      timed_out = 1'b1;
    end else begin
      @(posedge clock);
      start <= 1'b1;
      hold <= mode == 8'd3;
      drive_cycle(1'b1, 1'b1, 8'h00);
      drive_cycle(1'b1, 1'b0, 8'h10);
      for (n = 0; n < count; n++) begin
        if (gap_bit() && gap_bit()) begin
          drive_cycle(1'b1, 1'b0, 8'h10);
        end
        drive_cycle(1'b1, 1'b1, exp_bytes[n]);
      end
      case (mode)
        8'd1: drive_cycle(1'b1, 1'b0, 8'h30);
        8'd2: drive_cycle(1'b0, 1'b0, 8'h00);
        default: drive_cycle(1'b1, 1'b0, 8'h00);
      endcase
      end_cycle = cycle + 1;
      drive_cycle(1'b0, 1'b0, 8'h00);
      wait_cnt = 0;
      while (!done && wait_cnt < 1000) begin
        @(posedge clock);
        wait_cnt++;
        // Held credits come back once the packet has been cut off
        if (wait_cnt == 10) begin
          hold <= 1'b0;
        end
      end
      if (!done) begin
        $display("timeout waiting for the monitor to finish test %0d", test_no);
        timed_out = 1'b1;
      end
    end
  endtask

  initial begin
    $readmemh("verification/usb_rx_input.mem", mem);
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    p = 0;
    while (mem[p] != 8'h00 && p < 960 && !timed_out) begin
      test_no = mem[p];
      mode = mem[p + 1];
      count = mem[p + 2];
      for (i = 0; i < 32; i++) begin
        exp_bytes[i] = (i < count) ? mem[p + 3 + i] : 8'h00;
      end
      q = p + 3 + int'(count);
      exp_type = mem[q][1:0];
      exp_status = mem[q + 1][1:0];
      exp_kind = mem[q + 2][2:0];
      exp_addr = mem[q + 3][6:0];
      exp_endp = mem[q + 4][3:0];
      exp_kept = mem[q + 5];
      p = q + 6;
      send_packet();
    end
    @(posedge clock);
    $display("%0d tests run, %0d passed, %0d failed", tests, tests - fails, fails);
    if (fails == 0 && tests > 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/usb_rx_input.mem
// test mode(0 normal 1 rxerror 2 dirdrop 3 hold) count bytes...
// type(0 stream 1 token 2 none) status kind addr endp kept
01 0 0B C3 80 06 00 01 00 00 40 00 DD 94 0 0 0 00 0 0B
02 0 03 4B 00 00 0 0 0 00 0 03
03 0 0B C3 81 06 00 01 00 00 40 00 DD 94 0 1 0 00 0 0B
04 0 03 C7 00 00 0 2 0 00 0 03
05 0 03 2D 00 10 1 0 3 00 0 00
06 0 03 E1 80 A0 1 0 0 00 1 00
07 0 03 69 01 E8 1 0 2 01 0 00
08 0 03 B4 00 10 1 0 4 00 0 00
09 0 03 A5 00 10 1 0 1 00 0 00
0A 0 03 69 00 18 2 0 0 00 0 00
0B 0 01 D2 0 0 0 00 0 01
0C 1 03 C3 80 06 0 2 0 00 0 03
0D 2 03 C3 80 06 0 2 0 00 0 03
0E 3 1A C3 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11 12 13 14 15 16 17 18 19
0 3 0 00 0 13
0F 0 0B C3 80 06 00 01 00 00 40 00 DD 94 0 0 0 00 0 0B
00

//--- project.f
+incdir+include
logic/usb_rx_pkg.sv
logic/usb_byte_if.sv
logic/ulpi_rx_framer.sv
logic/usb_token_parser.sv
logic/usb_crc16_checker.sv
logic/usb_rx_merger.sv
logic/usb_ulpi_rx.sv
verification/usb_rx_properties.sv
verification/usb_rx_monitor.sv
verification/usb_ulpi_rx_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := usb_ulpi_rx_tb
FILELIST   := project.f
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
